//--- hw/div_settings.svh
// Build-time sizes for the divide unit
// The datapath is written for RV32 and has only been sized for a 32-bit word
// DIV_STEPS must stay at DIV_XLEN plus one because the core spends one extra
// cycle on the final remainder restore
`ifndef DIV_SETTINGS_SVH
`define DIV_SETTINGS_SVH

// ----------------------------------------
// Datapath width
// ----------------------------------------

// Operand and result width in bits
`define DIV_XLEN 32

// ----------------------------------------
// Core latency
// ----------------------------------------

// One cycle per quotient bit plus the remainder restore step
`define DIV_STEPS 33

`endif

//--- hw/div_pkg.sv
// Types shared by the divide unit stages
// The enum values must match the decoder that drives op_i in the core
// The sideband record is opaque to the divider and is only read by the result stage

`include "div_settings.svh"

package div_pkg;

    // Operand and result word
    typedef logic [`DIV_XLEN-1:0] word_t;

    // The four RV32M divide operations
    typedef enum logic [1:0] {
        DIV  = 2'b00,
        DIVU = 2'b01,
        REM  = 2'b10,
        REMU = 2'b11
    } div_op_t;

    // Sideband that rides next to the core while it iterates
    // It carries what the result stage needs to undo the sign stripping
    typedef struct packed {
        // Operation, selects quotient or remainder at the end
        div_op_t op;
        // Quotient takes the XOR of the operand signs
        logic    neg_quot;
        // Remainder follows the sign of the dividend
        logic    neg_rem;
        // Original dividend, which is the remainder on divide by zero
        word_t   dividend;
    } div_side_t;

endpackage

//--- hw/div_operand_stage.sv
// First stage of the divide unit
// Signed operands are turned into magnitudes here so the core only sees unsigned values
// The most negative value maps onto itself, which the core reads as 2**(XLEN-1)
// Holds one operation and accepts a new one in the cycle it hands the old one on

`timescale 1ns/1ps
`include "div_settings.svh"

module div_operand_stage (
    input  logic               clk_i,
    input  logic               rst_n_i,

    // Upstream handshake and operands
    input  logic               in_valid_i,
    output logic               in_ready_o,
    input  div_pkg::div_op_t   op_i,
    input  div_pkg::word_t     dividend_i,
    input  div_pkg::word_t     divisor_i,

    // Downstream handshake towards the core
    output logic               opnd_valid_o,
    input  logic               opnd_ready_i,
    output div_pkg::word_t     mag_dividend_o,
    output div_pkg::word_t     mag_divisor_o,
    output div_pkg::div_side_t side_o
);

    // ----------------------------------------
    // Sign decode
    // ----------------------------------------

    logic               is_signed;
    logic               dvd_neg;
    logic               dvs_neg;
    div_pkg::word_t     dvd_mag;
    div_pkg::word_t     dvs_mag;
    div_pkg::div_side_t side_d;
    logic               load;

    // Only DIV and REM treat the operands as two's complement
    assign is_signed = (op_i == div_pkg::DIV) || (op_i == div_pkg::REM);

    assign dvd_neg = is_signed & dividend_i[`DIV_XLEN-1];
    assign dvs_neg = is_signed & divisor_i[`DIV_XLEN-1];

    // Negate the negative operands to get their magnitudes
    assign dvd_mag = dvd_neg ? (~dividend_i + 1'b1) : dividend_i;
    assign dvs_mag = dvs_neg ? (~divisor_i + 1'b1) : divisor_i;

    always_comb begin
        side_d.op       = op_i;
        // Quotient is negative when exactly one operand was negative
        side_d.neg_quot = dvd_neg ^ dvs_neg;
        // The remainder keeps the sign of the dividend in RISC-V
        side_d.neg_rem  = dvd_neg;
        side_d.dividend = dividend_i;
    end

    // ----------------------------------------
    // One-entry register
    // ----------------------------------------

    // Ready while empty, or while the current entry leaves in this cycle
    assign in_ready_o = ~opnd_valid_o | opnd_ready_i;
    assign load       = in_valid_i & in_ready_o;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            opnd_valid_o <= 1'b0;
        end else if (in_ready_o) begin
            // Either refilled by a new operation or drained to empty
            opnd_valid_o <= in_valid_i;
        end
    end

    // Payload only moves on an accepted input
    always_ff @(posedge clk_i) begin
        if (load) begin
            mag_dividend_o <= dvd_mag;
            mag_divisor_o  <= dvs_mag;
            side_o         <= side_d;
        end
    end

endmodule

//--- hw/div_nonrestoring_core.sv
// Iterative non-restoring divider on unsigned magnitudes
// Takes exactly DIV_STEPS cycles from acceptance to a valid result
// Accepts a new operation only when idle, so there is no overlap inside the core
// The sideband is carried along untouched and may be of any type
// A zero divisor still runs the full sequence and yields all ones and the dividend

`timescale 1ns/1ps
`include "div_settings.svh"

module div_nonrestoring_core #(
    parameter type SIDE_T = logic
) (
    input  logic           clk_i,
    input  logic           rst_n_i,

    // Operand side
    input  logic           in_valid_i,
    output logic           in_ready_o,
    input  div_pkg::word_t dividend_i,
    input  div_pkg::word_t divisor_i,
    input  SIDE_T          side_i,

    // Result side
    output logic           out_valid_o,
    input  logic           out_ready_i,
    output div_pkg::word_t quotient_o,
    output div_pkg::word_t remainder_o,
    output logic           div_zero_o,
    output SIDE_T          side_o
);

    localparam int XLEN  = `DIV_XLEN;
    // Iterations are the total steps minus the restore cycle
    localparam int ITERS = `DIV_STEPS - 1;
    localparam int CNT_W = $clog2(ITERS);

    typedef enum logic [1:0] {
        S_IDLE,
        S_ITER,
        S_RESTORE,
        S_DONE
    } state_t;

    state_t           state_q;
    logic [CNT_W-1:0] step_q;
    // Partial remainder with one extra bit as the sign
    logic [XLEN:0]    acc_q;
    logic [XLEN:0]    acc_shift;
    logic [XLEN:0]    acc_next;
    // Dividend bits shift out at the top while quotient bits enter at the bottom
    div_pkg::word_t   quot_q;
    div_pkg::word_t   quot_next;
    div_pkg::word_t   divisor_q;
    logic             div_zero_q;
    SIDE_T            side_q;
    logic             accept;

    assign in_ready_o = (state_q == S_IDLE);
    assign accept     = in_valid_i & in_ready_o;

    // ----------------------------------------
    // Iteration datapath
    // ----------------------------------------

    always_comb begin
        // Bring the next dividend bit into the partial remainder
        acc_shift = {acc_q[XLEN-1:0], quot_q[XLEN-1]};
        // The sign before the shift is the true sign even when the shift wraps
        if (acc_q[XLEN]) begin
            acc_next = acc_shift + {1'b0, divisor_q};
        end else begin
            acc_next = acc_shift - {1'b0, divisor_q};
        end
        // A non-negative result means the divisor fitted
        quot_next = {quot_q[XLEN-2:0], ~acc_next[XLEN]};
    end

    // ----------------------------------------
    // Control FSM
    // ----------------------------------------

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= S_IDLE;
            step_q  <= '0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (accept) begin
                        state_q <= S_ITER;
                        step_q  <= '0;
                    end
                end
                S_ITER: begin
                    step_q <= step_q + 1'b1;
                    if (step_q == CNT_W'(ITERS - 1)) begin
                        state_q <= S_RESTORE;
                    end
                end
                S_RESTORE: state_q <= S_DONE;
                // Result is held until the result stage takes it
                S_DONE: begin
                    if (out_ready_i) begin
                        state_q <= S_IDLE;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            acc_q      <= '0;
            quot_q     <= dividend_i;
            divisor_q  <= divisor_i;
            div_zero_q <= (divisor_i == '0);
            side_q     <= side_i;
        end else if (state_q == S_ITER) begin
            acc_q  <= acc_next;
            quot_q <= quot_next;
        end else if ((state_q == S_RESTORE) && acc_q[XLEN]) begin
            // Final correction when the last step left a negative remainder
            acc_q <= acc_q + {1'b0, divisor_q};
        end
    end

    assign out_valid_o = (state_q == S_DONE);
    assign quotient_o  = quot_q;
    assign remainder_o = acc_q[XLEN-1:0];
    assign div_zero_o  = div_zero_q;
    assign side_o      = side_q;

endmodule

//--- hw/div_result_stage.sv
// Last stage of the divide unit
// Puts the signs back, applies the RISC-V divide-by-zero result and picks the output
// Signed overflow needs no special case since the magnitudes already give 0x8000_0000
// and a zero remainder
// The output register accepts a new result in the same cycle the old one is taken

`timescale 1ns/1ps

module div_result_stage (
    input  logic               clk_i,
    input  logic               rst_n_i,

    // From the core
    input  logic               core_valid_i,
    output logic               core_ready_o,
    input  div_pkg::word_t     quotient_i,
    input  div_pkg::word_t     remainder_i,
    input  logic               div_zero_i,
    input  div_pkg::div_side_t side_i,

    // To the writeback
    output logic               out_valid_o,
    input  logic               out_ready_i,
    output div_pkg::word_t     result_o,
    output logic               div_zero_o
);

    // ----------------------------------------
    // Sign restore and select
    // ----------------------------------------

    div_pkg::word_t quot_fix;
    div_pkg::word_t rem_fix;
    div_pkg::word_t result_d;
    logic           load;

    always_comb begin
        if (div_zero_i) begin
            // Divide by zero returns all ones and the untouched dividend
            quot_fix = '1;
            rem_fix  = side_i.dividend;
        end else begin
            quot_fix = side_i.neg_quot ? (~quotient_i + 1'b1) : quotient_i;
            rem_fix  = side_i.neg_rem ? (~remainder_i + 1'b1) : remainder_i;
        end

        // Quotient for the divide ops and remainder for the rest
        case (side_i.op)
            div_pkg::DIV,
            div_pkg::DIVU: result_d = quot_fix;
            default:       result_d = rem_fix;
        endcase
    end

    // ----------------------------------------
    // Output register
    // ----------------------------------------

    // Take a new result while empty or while the held one is being consumed
    assign core_ready_o = ~out_valid_o | out_ready_i;
    assign load         = core_valid_i & core_ready_o;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            out_valid_o <= 1'b0;
        end else if (core_ready_o) begin
            out_valid_o <= core_valid_i;
        end
    end

    // Result and flag change only on a transfer from the core
    always_ff @(posedge clk_i) begin
        if (load) begin
            result_o   <= result_d;
            div_zero_o <= div_zero_i;
        end
    end

endmodule

//--- hw/div_unit_top.sv
// Integer divide unit for the RV32 core
// Three stages with valid/ready between them and up to three operations in flight
// An isolated operation shows up on the output 35 cycles after it is accepted
// Results always leave in the order they came in

`timescale 1ns/1ps

module div_unit_top (
    input  logic             clk_i,
    input  logic             rst_n_i,

    // Issue side
    input  logic             in_valid_i,
    output logic             in_ready_o,
    input  div_pkg::div_op_t op_i,
    input  div_pkg::word_t   dividend_i,
    input  div_pkg::word_t   divisor_i,

    // Writeback side
    output logic             out_valid_o,
    input  logic             out_ready_i,
    output div_pkg::word_t   result_o,
    output logic             div_zero_o
);

    // ----------------------------------------
    // Inter-stage links
    // ----------------------------------------

    logic               opnd_valid;
    logic               opnd_ready;
    div_pkg::word_t     mag_dividend;
    div_pkg::word_t     mag_divisor;
    div_pkg::div_side_t side;

    logic               core_valid;
    logic               core_ready;
    div_pkg::word_t     quotient;
    div_pkg::word_t     remainder;
    logic               div_zero;
    div_pkg::div_side_t side_out;

    div_operand_stage u_operand (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .in_valid_i     (in_valid_i),
        .in_ready_o     (in_ready_o),
        .op_i           (op_i),
        .dividend_i     (dividend_i),
        .divisor_i      (divisor_i),
        .opnd_valid_o   (opnd_valid),
        .opnd_ready_i   (opnd_ready),
        .mag_dividend_o (mag_dividend),
        .mag_divisor_o  (mag_divisor),
        .side_o         (side)
    );

    // The core only carries the sideband and never looks inside it
    div_nonrestoring_core #(
        .SIDE_T (div_pkg::div_side_t)
    ) u_core (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .in_valid_i  (opnd_valid),
        .in_ready_o  (opnd_ready),
        .dividend_i  (mag_dividend),
        .divisor_i   (mag_divisor),
        .side_i      (side),
        .out_valid_o (core_valid),
        .out_ready_i (core_ready),
        .quotient_o  (quotient),
        .remainder_o (remainder),
        .div_zero_o  (div_zero),
        .side_o      (side_out)
    );

    div_result_stage u_result (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .core_valid_i (core_valid),
        .core_ready_o (core_ready),
        .quotient_i   (quotient),
        .remainder_i  (remainder),
        .div_zero_i   (div_zero),
        .side_i       (side_out),
        .out_valid_o  (out_valid_o),
        .out_ready_i  (out_ready_i),
        .result_o     (result_o),
        .div_zero_o   (div_zero_o)
    );

endmodule

//--- tests/div_unit_asserts.sv
// Handshake properties for the divide unit, bound into div_unit_top
// Sampled on the rising edge and held off while reset is low, except the reset check
// Covers the output link and the link from the operand stage into the core

`timescale 1ns/1ps

module div_unit_asserts (
    input logic           clk_i,
    input logic           rst_n_i,
    input logic           out_valid_i,
    input logic           out_ready_i,
    input div_pkg::word_t result_i,
    input logic           div_zero_i,
    input logic           opnd_valid_i,
    input logic           opnd_ready_i
);

    // A stalled output keeps its valid and its data
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (out_valid_i && !out_ready_i) |=>
            (out_valid_i && $stable(result_i) && $stable(div_zero_i)))
        else $error("Output changed while stalled");

    assert property (@(posedge clk_i) !rst_n_i |=> !out_valid_i)
        else $error("out_valid_o high right after reset");

    // Once the core takes an operation it is busy and must not take another
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (opnd_valid_i && opnd_ready_i) |=> !opnd_ready_i)
        else $error("Core ready again right after accepting");

    // An operand offer that is not taken stays up
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (opnd_valid_i && !opnd_ready_i) |=> opnd_valid_i)
        else $error("Operand valid dropped before transfer");

endmodule

bind div_unit_top div_unit_asserts u_asserts (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .out_valid_i  (out_valid_o),
    .out_ready_i  (out_ready_i),
    .result_i     (result_o),
    .div_zero_i   (div_zero_o),
    .opnd_valid_i (opnd_valid),
    .opnd_ready_i (opnd_ready)
);

//--- tests/div_unit_tb.sv
// Testbench for the divide unit
// Runs a directed table first, then random operations with random output stalls
// Expected values come from a reference model of the RISC-V divide rules
// Inputs change on the falling edge and the output handshake is judged there too

`timescale 1ns/1ps
`include "div_settings.svh"

module div_unit_tb;

    localparam int N_DIR     = 24;
    localparam int N_RAND    = 200;
    // Directed entries, random entries and the single latency probe
    localparam int N_ENTRIES = N_DIR + N_RAND + 1;
    localparam int LIMIT     = N_ENTRIES * 35 * 4 + 100;
    // Percentage of cycles with out_ready_i low during the random part
    localparam int STALL_PCT = 40;
    localparam int LATENCY   = `DIV_STEPS + 2;

    logic             clk_i;
    logic             rst_n_i;
    logic             in_valid_i;
    logic             in_ready_o;
    div_pkg::div_op_t op_i;
    div_pkg::word_t   dividend_i;
    div_pkg::word_t   divisor_i;
    logic             out_valid_o;
    logic             out_ready_i;
    div_pkg::word_t   result_o;
    logic             div_zero_o;

    // Directed stimulus and expected values
    div_pkg::div_op_t tbl_op[$];
    div_pkg::word_t   tbl_a[$];
    div_pkg::word_t   tbl_b[$];
    div_pkg::word_t   tbl_res[$];
    logic             tbl_dz[$];

    // Scoreboard in issue order
    div_pkg::word_t   exp_res[$];
    logic             exp_dz[$];
    int               exp_id[$];

    int               chk_errors;
    int               ctl_errors;
    int               checks;
    int               sent;
    int               cycles;
    bit               stall_en;

    div_unit_top uut (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .op_i        (op_i),
        .dividend_i  (dividend_i),
        .divisor_i   (divisor_i),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i),
        .result_o    (result_o),
        .div_zero_o  (div_zero_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // ----------------------------------------
    // Reference model and helpers
    // ----------------------------------------

    // Signed division in SV truncates toward zero and the remainder follows the dividend
    function automatic div_pkg::word_t ref_result(input div_pkg::div_op_t op,
                                                  input div_pkg::word_t a,
                                                  input div_pkg::word_t b);
        logic signed [`DIV_XLEN-1:0] sa;
        logic signed [`DIV_XLEN-1:0] sb;
        div_pkg::word_t              q;
        div_pkg::word_t              r;
        sa = a;
        sb = b;
        if (b == '0) begin
            q = '1;
            r = a;
        end else if (op == div_pkg::DIVU || op == div_pkg::REMU) begin
            q = a / b;
            r = a % b;
        end else if (a == 32'h8000_0000 && b == 32'hffff_ffff) begin
            // Signed overflow wraps back to the most negative value
            q = a;
            r = '0;
        end else begin
            q = sa / sb;
            r = sa % sb;
        end
        if (op == div_pkg::DIV || op == div_pkg::DIVU) begin
            return q;
        end else begin
            return r;
        end
    endfunction

    task automatic add_entry(input div_pkg::div_op_t op, input div_pkg::word_t a,
                             input div_pkg::word_t b, input div_pkg::word_t res,
                             input logic dz);
        tbl_op.push_back(op);
        tbl_a.push_back(a);
        tbl_b.push_back(b);
        tbl_res.push_back(res);
        tbl_dz.push_back(dz);
    endtask

    task automatic load_table();
        // Unsigned ops including a small dividend and all-ones operands
        add_entry(div_pkg::DIVU, 32'h0000_0064, 32'h0000_0007, 32'h0000_000e, 1'b0);
        add_entry(div_pkg::REMU, 32'h0000_0064, 32'h0000_0007, 32'h0000_0002, 1'b0);
        add_entry(div_pkg::DIVU, 32'h0000_0005, 32'h0000_0009, 32'h0000_0000, 1'b0);
        add_entry(div_pkg::REMU, 32'h0000_0005, 32'h0000_0009, 32'h0000_0005, 1'b0);
        add_entry(div_pkg::DIVU, 32'hffff_ffff, 32'hffff_ffff, 32'h0000_0001, 1'b0);
        add_entry(div_pkg::REMU, 32'hffff_ffff, 32'hffff_ffff, 32'h0000_0000, 1'b0);
        add_entry(div_pkg::DIVU, 32'hffff_ffff, 32'h0000_0001, 32'hffff_ffff, 1'b0);
        add_entry(div_pkg::REMU, 32'hffff_ffff, 32'h0000_0010, 32'h0000_000f, 1'b0);
        add_entry(div_pkg::DIVU, 32'h8000_0000, 32'h0000_0003, 32'h2aaa_aaaa, 1'b0);
        // All four sign combinations of 7 and 2 for the signed ops
        add_entry(div_pkg::DIV,  32'h0000_0007, 32'h0000_0002, 32'h0000_0003, 1'b0);
        add_entry(div_pkg::DIV,  32'hffff_fff9, 32'h0000_0002, 32'hffff_fffd, 1'b0);
        add_entry(div_pkg::DIV,  32'h0000_0007, 32'hffff_fffe, 32'hffff_fffd, 1'b0);
        add_entry(div_pkg::DIV,  32'hffff_fff9, 32'hffff_fffe, 32'h0000_0003, 1'b0);
        add_entry(div_pkg::REM,  32'h0000_0007, 32'h0000_0002, 32'h0000_0001, 1'b0);
        add_entry(div_pkg::REM,  32'hffff_fff9, 32'h0000_0002, 32'hffff_ffff, 1'b0);
        add_entry(div_pkg::REM,  32'h0000_0007, 32'hffff_fffe, 32'h0000_0001, 1'b0);
        add_entry(div_pkg::REM,  32'hffff_fff9, 32'hffff_fffe, 32'hffff_ffff, 1'b0);
        // Overflow and the most negative dividend
        add_entry(div_pkg::DIV,  32'h8000_0000, 32'hffff_ffff, 32'h8000_0000, 1'b0);
        add_entry(div_pkg::REM,  32'h8000_0000, 32'hffff_ffff, 32'h0000_0000, 1'b0);
        add_entry(div_pkg::DIV,  32'h8000_0000, 32'h0000_0002, 32'hc000_0000, 1'b0);
        // Divide by zero for signed and unsigned ops
        add_entry(div_pkg::DIV,  32'h1234_5678, 32'h0000_0000, 32'hffff_ffff, 1'b1);
        add_entry(div_pkg::REM,  32'hffff_fff9, 32'h0000_0000, 32'hffff_fff9, 1'b1);
        add_entry(div_pkg::DIVU, 32'hdead_beef, 32'h0000_0000, 32'hffff_ffff, 1'b1);
        add_entry(div_pkg::REMU, 32'hdead_beef, 32'h0000_0000, 32'hdead_beef, 1'b1);
    endtask

    // Presents one operation and returns once it will be taken at the next rising edge
    task automatic send(input div_pkg::div_op_t op, input div_pkg::word_t a,
                        input div_pkg::word_t b, input div_pkg::word_t res, input logic dz);
        @(negedge clk_i);
        in_valid_i = 1'b1;
        op_i       = op;
        dividend_i = a;
        divisor_i  = b;
        exp_res.push_back(res);
        exp_dz.push_back(dz);
        exp_id.push_back(sent);
        sent++;
        while (!in_ready_o) begin
            @(negedge clk_i);
        end
    endtask

    task automatic idle_input();
        @(negedge clk_i);
        in_valid_i = 1'b0;
    endtask

    task automatic wait_drained();
        while (exp_res.size() != 0) begin
            @(negedge clk_i);
        end
        @(negedge clk_i);
    endtask

    task automatic check_output();
        div_pkg::word_t want_res;
        logic           want_dz;
        int             id;
        if (exp_res.size() == 0) begin
            chk_errors++;
            $display("Unexpected result %h at %0t with no operation outstanding",
                     result_o, $time);
        end else begin
            want_res = exp_res.pop_front();
            want_dz  = exp_dz.pop_front();
            id       = exp_id.pop_front();
            checks++;
            if (result_o !== want_res) begin
                chk_errors++;
                $display("FAILED %0t: operation %0d gave result %h, expected %h",
                         $time, id, result_o, want_res);
            end
            if (div_zero_o !== want_dz) begin
                chk_errors++;
                $display("FAILED %0t: operation %0d gave div_zero %b, expected %b",
                         $time, id, div_zero_o, want_dz);
            end
        end
    endtask

    // ----------------------------------------
    // Output side, stalls and watchdog
    // ----------------------------------------

    // The ready value set here is the one the next rising edge sees
    initial begin : output_side
        out_ready_i = 1'b1;
        forever begin
            @(negedge clk_i);
            if (stall_en) begin
                out_ready_i = (($urandom % 100) >= STALL_PCT);
            end else begin
                out_ready_i = 1'b1;
            end
            if (rst_n_i && out_valid_o && out_ready_i) begin
                check_output();
            end
        end
    end

    initial begin : watchdog
        cycles = 0;
        forever begin
            @(posedge clk_i);
            cycles++;
            if (cycles >= LIMIT) begin
                $display("Timeout after %0d cycles with %0d results still outstanding",
                         cycles, exp_res.size());
                $display("Errors found");
                $finish;
            end
        end
    end

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------

    initial begin : main
        div_pkg::div_op_t op;
        div_pkg::word_t   a;
        div_pkg::word_t   b;
        logic [1:0]       sel;
        int               lat;
        void'($urandom(32'hffae));
        chk_errors = 0;
        ctl_errors = 0;
        checks     = 0;
        sent       = 0;
        stall_en   = 1'b0;
        rst_n_i    = 1'b0;
        in_valid_i = 1'b0;
        op_i       = div_pkg::DIVU;
        dividend_i = '0;
        divisor_i  = '0;
        load_table();

        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;

        // Reset state seen after the first clock out of reset
        @(negedge clk_i);
        if (out_valid_o !== 1'b0) begin
            ctl_errors++;
            $display("FAILED %0t: out_valid_o is %b after reset, expected 0", $time, out_valid_o);
        end
        if (in_ready_o !== 1'b1) begin
            ctl_errors++;
            $display("FAILED %0t: in_ready_o is %b after reset, expected 1", $time, in_ready_o);
        end

        for (int i = 0; i < tbl_op.size(); i++) begin
            send(tbl_op[i], tbl_a[i], tbl_b[i], tbl_res[i], tbl_dz[i]);
        end
        idle_input();
        wait_drained();

        // Single operation into an empty pipeline with latency counted in whole cycles
        send(div_pkg::DIVU, 32'd1000, 32'd10, 32'd100, 1'b0);
        @(negedge clk_i);
        in_valid_i = 1'b0;
        // This falling edge lies in the cycle that starts with the input handshake
        lat = 0;
        while (!out_valid_o) begin
            @(negedge clk_i);
            lat++;
        end
        if (lat != LATENCY) begin
            ctl_errors++;
            $display("FAILED %0t: latency %0d cycles, expected %0d", $time, lat, LATENCY);
        end
        wait_drained();

        stall_en = 1'b1;
        for (int n = 0; n < N_RAND; n++) begin
            sel = 2'($urandom % 4);
            op  = div_pkg::div_op_t'(sel);
            a   = $urandom;
            b   = $urandom;
            // Bias towards the corner cases of the divide rules
            case ($urandom % 8)
                0: b = '0;
                1: b = '1;
                2: b = $urandom % 16;
                3: a = 32'h8000_0000;
                4: begin
                    a = 32'h8000_0000;
                    b = '1;
                end
                default: ;
            endcase
            send(op, a, b, ref_result(op, a, b), b == '0);
        end
        idle_input();
        wait_drained();
        stall_en = 1'b0;

        $display("Results checked: %0d of %0d, value errors: %0d, control errors: %0d",
                 checks, sent, chk_errors, ctl_errors);
        if (chk_errors == 0 && ctl_errors == 0 && checks == sent) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+hw
hw/div_pkg.sv
hw/div_operand_stage.sv
hw/div_nonrestoring_core.sv
hw/div_result_stage.sv
hw/div_unit_top.sv
tests/div_unit_asserts.sv
tests/div_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the divide unit testbench with Verilator and run it once
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module div_unit_tb -o div_unit_sim \
    || { echo "Verilator build failed"; exit 1; }

sim_out=$(./obj_dir/div_unit_sim)
echo "$sim_out"
echo "$sim_out" | grep -qx "No errors" && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
